// ==== common/qmem_pkg.sv ====
////////////////////////////////////////////////////////////
// shared QMEM bus widths and region codes for the boot memory
// the address union gives the flash and scratch RAM decodes of one word
////////////////////////////////////////////////////////////

package qmem_pkg;

  // bus widths
  localparam int QAW = 24;        // byte address bits
  localparam int QDW = 32;        // data bits
  localparam int QSW = QDW / 8;   // byte selects

  // flash device widths
  localparam int FAW = 22;        // incl. boot_sel as top bit
  localparam int FDW = 8;         // parallel NOR, byte mode

  // word index widths per region view
  localparam int FL_WORD_W  = FAW - 3;  // minus boot_sel and lane bits
  localparam int RAM_WORD_W = 11;       // up to 2k words of scratch

  // padding so both views fill the whole word
  localparam int FL_PAD_W  = QAW - 1 - FL_WORD_W - 2;
  localparam int RAM_PAD_W = QAW - 1 - RAM_WORD_W - 2;

  // region bit sits at the top of the address (bit 23)
  localparam logic region_flash = 1'b0;
  localparam logic region_ram   = 1'b1;

  ////////////////////////////////////////////////////////////
  // bus address word, decoded per region
  ////////////////////////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic                 region;  // region select
      logic [FL_PAD_W-1:0]  pad;
      logic [FL_WORD_W-1:0] word;    // 32-bit word in flash image
      logic [1:0]           lane;    // byte within word
    } flash_view;
    struct packed {
      logic                  region;
      logic [RAM_PAD_W-1:0]  pad;    // unused upper bits
      logic [RAM_WORD_W-1:0] word;   // RAM word index
      logic [1:0]            lane;
    } ram_view;
  } qmem_adr_u;

endpackage

// ==== common/qmem_if.sv ====
////////////////////////////////////////////////////////////
// QMEM bus bundle between decoder and slaves
// master holds request until ack, slave pulses ack one cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface qmem_if;
  import qmem_pkg::*;

  // request side
  qmem_adr_u        adr;    // byte address, region decoded
  logic             cs;     // request valid
  logic             we;     // write when high
  logic [QSW-1:0]   sel;    // byte lane selects
  logic [QDW-1:0]   dat_w;  // write data

  // response side
  logic [QDW-1:0]   dat_r;  // valid the cycle after ack
  logic             ack;    // single cycle pulse
  logic             err;    // qualifies ack

  // bus master end
  modport master (
    output adr, cs, we, sel, dat_w,
    input  dat_r, ack, err
  );

  // bus slave end
  modport slave (
    input  adr, cs, we, sel, dat_w,
    output dat_r, ack, err
  );

endinterface

// ==== rtl/qmem_decoder.sv ====
////////////////////////////////////////////////////////////
// region decoder between the host bus and the two slaves
// adds no latency, read data steered by the last acked region
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module qmem_decoder (
  input  logic   clk,
  input  logic   rst,
  qmem_if.slave  host,       // from bus master
  qmem_if.master flash_bus,  // to flash controller
  qmem_if.master ram_bus     // to scratch RAM
);
  import qmem_pkg::*;

  logic region;       // region of current request
  logic last_region;  // region of last acked request

  // top address bit picks the slave
  assign region = host.adr.flash_view.region;

  ////////////////////////////////////////////////////////////
  // request routing
  ////////////////////////////////////////////////////////////

  // only cs is gated, the rest fans out to both
  assign flash_bus.cs    = host.cs && (region == region_flash);
  assign flash_bus.adr   = host.adr;
  assign flash_bus.we    = host.we;
  assign flash_bus.sel   = host.sel;
  assign flash_bus.dat_w = host.dat_w;

  assign ram_bus.cs    = host.cs && (region == region_ram);
  assign ram_bus.adr   = host.adr;
  assign ram_bus.we    = host.we;
  assign ram_bus.sel   = host.sel;
  assign ram_bus.dat_w = host.dat_w;

  ////////////////////////////////////////////////////////////
  // response steering
  ////////////////////////////////////////////////////////////

  // one request in flight, so at most one slave acks
  assign host.ack = flash_bus.ack | ram_bus.ack;
  assign host.err = flash_bus.err | ram_bus.err;

  // remember who answered, data shows up one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_region <= region_flash;
    end else if (host.ack) begin
      last_region <= region;  // adr still held in ack cycle
    end
  end

  // data mux, holds until the next request completes
  assign host.dat_r = (last_region == region_ram) ? ram_bus.dat_r
                                                  : flash_bus.dat_r;

endmodule

// ==== ctrl_flash/ctrl_flash.sv ====
////////////////////////////////////////////////////////////
// parallel NOR flash read engine, 4 byte reads per bus word
// flash stays in read mode, writes are refused with err
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ctrl_flash #(
  parameter int DLY = 3,  // flash access time in clocks (2 or 3)
  parameter int BE  = 1   // 1 big endian, 2 little endian
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       boot_sel,  // picks flash image half
  qmem_if.slave                      bus,
  output logic [qmem_pkg::FAW-1:0]   fl_adr,
  output logic                       fl_ce_n,
  output logic                       fl_we_n,
  output logic                       fl_oe_n,
  output logic                       fl_rst_n,
  input  logic [qmem_pkg::FDW-1:0]   fl_dat_r
);
  import qmem_pkg::*;

  // enough bits to hold DLY-1
  localparam int CW = (DLY > 2) ? $clog2(DLY) : 1;

  // FSM encoding, low bits of a read state are the byte lane
  localparam logic [2:0] S_ID = 3'h0;
  localparam logic [2:0] S_R1 = 3'h4;
  localparam logic [2:0] S_R2 = 3'h5;
  localparam logic [2:0] S_R3 = 3'h6;
  localparam logic [2:0] S_R4 = 3'h7;

  logic [2:0]     state;
  logic [CW-1:0]  cnt;       // access timer, counts down to 0
  logic [1:0]     lane;      // byte lane in flight
  logic [1:0]     pos;       // lane position in the bus word
  logic           done;      // byte on fl_dat_r is valid
  logic           ack_q;
  logic           err_q;
  logic [QDW-1:0] dat_q;     // assembled word

  ////////////////////////////////////////////////////////////
  // flash pins held in read mode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fl_ce_n  <= 1'b1;
      fl_we_n  <= 1'b1;
      fl_oe_n  <= 1'b1;
      fl_rst_n <= 1'b0;  // device in reset
    end else begin
      fl_ce_n  <= 1'b0;  // chip always selected
      fl_we_n  <= 1'b1;  // never write
      fl_oe_n  <= 1'b0;
      fl_rst_n <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // read FSM
  ////////////////////////////////////////////////////////////

  assign lane = state[1:0];
  assign done = state[2] && (cnt == '0);  // any read state, timer out

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_ID;
      cnt   <= '0;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= 1'b0;  // pulses only
      err_q <= 1'b0;
      if (cnt != '0) cnt <= cnt - 1'b1;
      case (state)
        S_ID: begin
          // skip the cycle of our own ack, cs is still up then
          if (bus.cs && !ack_q) begin
            if (bus.we) begin
              ack_q <= 1'b1;  // no programming, refuse at once
              err_q <= 1'b1;
            end else begin
              state <= S_R1;
              cnt   <= CW'(DLY - 1);
            end
          end
        end
        S_R1, S_R2, S_R3: begin
          if (done) begin
            state <= state + 3'h1;  // next lane
            cnt   <= CW'(DLY - 1);
          end
        end
        S_R4: begin
          if (cnt == CW'(1)) ack_q <= 1'b1;  // last cycle of byte 3
          if (done) state <= S_ID;
        end
        default: state <= S_ID;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // flash address and word assembly
  ////////////////////////////////////////////////////////////

  // address goes out with the state step
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fl_adr <= '0;
    end else if (state == S_ID && bus.cs && !bus.we && !ack_q) begin
      fl_adr <= {boot_sel, bus.adr.flash_view.word, 2'b00};
    end else if (done && state != S_R4) begin
      fl_adr <= {boot_sel, bus.adr.flash_view.word, lane + 2'b01};
    end
  end

  // byte lane 0 lands on top for big endian
  assign pos = (BE == 1) ? ~lane : lane;

  always_ff @(posedge clk) begin
    if (done) dat_q[8*pos +: 8] <= fl_dat_r;
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = err_q;

endmodule

// ==== rtl/scratch_ram.sv ====
////////////////////////////////////////////////////////////
// on-chip scratch RAM slave, single cycle ack
// writes honour byte selects, reads land one cycle after ack
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module scratch_ram #(
  parameter int RAM_AW = 11  // word address bits
) (
  input  logic  clk,
  input  logic  rst,
  qmem_if.slave bus
);
  import qmem_pkg::*;

  logic [QDW-1:0]    mem [0:(2**RAM_AW)-1];
  logic [RAM_AW-1:0] idx;    // word index from RAM view
  logic              ack_q;
  logic [QDW-1:0]    dat_q;  // read data register

  assign idx = bus.adr.ram_view.word[RAM_AW-1:0];

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // one cycle after cs, no back-to-back on the same request
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.cs && !ack_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // array access in the ack cycle
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ack_q && bus.we) begin
      for (int i = 0; i < QSW; i++) begin
        if (bus.sel[i]) mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];  // selected lanes only
      end
    end
  end

  // read word, held until the next read
  always_ff @(posedge clk) begin
    if (ack_q && !bus.we) dat_q <= mem[idx];
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;  // every access is legal here

endmodule

// ==== rtl/flash_subsys_top.sv ====
////////////////////////////////////////////////////////////
// boot memory subsystem top, host bus in plain ports
// flash region goes to the NOR controller, RAM region to scratch
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module flash_subsys_top #(
  parameter int DLY    = 3,   // flash access clocks
  parameter int BE     = 1,   // flash word byte order
  parameter int RAM_AW = 11   // scratch RAM word bits
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      boot_sel,
  // host bus
  input  logic [qmem_pkg::QAW-1:0]  adr,
  input  logic                      cs,
  input  logic                      we,
  input  logic [qmem_pkg::QSW-1:0]  sel,
  input  logic [qmem_pkg::QDW-1:0]  dat_w,
  output logic [qmem_pkg::QDW-1:0]  dat_r,
  output logic                      ack,
  output logic                      err,
  // flash device
  output logic [qmem_pkg::FAW-1:0]  fl_adr,
  output logic                      fl_ce_n,
  output logic                      fl_we_n,
  output logic                      fl_oe_n,
  output logic                      fl_rst_n,
  input  logic [qmem_pkg::FDW-1:0]  fl_dat_r
);

  qmem_if host_bus ();   // host side of decoder
  qmem_if flash_bus ();
  qmem_if ram_bus ();

  // bundle the plain host ports
  assign host_bus.adr   = adr;
  assign host_bus.cs    = cs;
  assign host_bus.we    = we;
  assign host_bus.sel   = sel;
  assign host_bus.dat_w = dat_w;
  assign dat_r          = host_bus.dat_r;
  assign ack            = host_bus.ack;
  assign err            = host_bus.err;

  qmem_decoder dec0 (
    .clk       (clk),
    .rst       (rst),
    .host      (host_bus.slave),
    .flash_bus (flash_bus.master),
    .ram_bus   (ram_bus.master)
  );

  ctrl_flash #(.DLY(DLY), .BE(BE)) flash0 (
    .clk      (clk),
    .rst      (rst),
    .boot_sel (boot_sel),
    .bus      (flash_bus.slave),
    .fl_adr   (fl_adr),
    .fl_ce_n  (fl_ce_n),
    .fl_we_n  (fl_we_n),
    .fl_oe_n  (fl_oe_n),
    .fl_rst_n (fl_rst_n),
    .fl_dat_r (fl_dat_r)
  );

  scratch_ram #(.RAM_AW(RAM_AW)) ram0 (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.slave)
  );

endmodule

// ==== testbench/flash_subsys_checker.sv ====
////////////////////////////////////////////////////////////
// reference model of the flash and scratch RAM regions
// watches the top ports, checks ack timing, err and read data
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module flash_subsys_checker #(
  parameter int DLY    = 3,
  parameter int BE     = 1,
  parameter int RAM_AW = 11
) (
  input logic                     clk,
  input logic                     rst,
  input logic                     boot_sel,
  input logic [qmem_pkg::QAW-1:0] adr,
  input logic                     cs,
  input logic                     we,
  input logic [qmem_pkg::QSW-1:0] sel,
  input logic [qmem_pkg::QDW-1:0] dat_w,
  input logic [qmem_pkg::QDW-1:0] dat_r,
  input logic                     ack,
  input logic                     err
);
  import qmem_pkg::*;

  logic [QDW-1:0]    shadow [0:(2**RAM_AW)-1];  // RAM contents written so far
  logic [QSW-1:0]    known  [0:(2**RAM_AW)-1];  // lanes written at least once
  qmem_adr_u         req_adr;                   // captured request
  logic              req_we;
  logic [QSW-1:0]    req_sel;
  logic [QDW-1:0]    req_dat;
  logic              req_boot;
  logic [RAM_AW-1:0] idx;
  logic              pending = 1'b0;            // request waiting for ack
  logic              rd_check = 1'b0;           // data cycle follows
  logic [QDW-1:0]    rd_exp;
  logic [QDW-1:0]    rd_mask;
  int                start_cyc;
  int                exp_lat;
  int                cyc = 0;                   // negedge count
  int                errors = 0;
  int                checks = 0;

  initial begin
    for (int i = 0; i < 2**RAM_AW; i++) known[i] = '0;
  end

  // content rule of the flash image, lane 0 first in memory
  function automatic logic [QDW-1:0] expect_flash_word(input logic b,
                                                       input logic [FL_WORD_W-1:0] w);
    logic [QDW-1:0] v;
    logic [FAW-1:0] fa;
    int             l;
    v = '0;
    for (l = 0; l < 4; l++) begin
      fa = {b, w, 2'(l)};
      if (BE == 1) v[8*(3-l) +: 8] = fa[7:0] ^ fa[15:8];  // big endian
      else v[8*l +: 8] = fa[7:0] ^ fa[15:8];
    end
    return v;
  endfunction

  function automatic logic [QDW-1:0] lanes_to_bits(input logic [QSW-1:0] k);
    logic [QDW-1:0] m;
    int             i;
    for (i = 0; i < QSW; i++) m[8*i +: 8] = {8{k[i]}};
    return m;
  endfunction

  task automatic compare_value(input string name, input logic [QDW-1:0] exp,
                               input logic [QDW-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s expected 0x%h got 0x%h at %0t ns", name, exp, got, $time);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("checker: %s at %0t ns", what, $time);
  endtask

  ////////////////////////////////////////////////////////////
  // sampled at negedge, away from the driving edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      compare_value("ack", '0, QDW'(ack));  // quiet bus in reset
      compare_value("err", '0, QDW'(err));
      pending  = 1'b0;
      rd_check = 1'b0;
    end else begin
      if (rd_check) begin
        compare_value("dat_r", rd_exp & rd_mask, dat_r & rd_mask);
        rd_check = 1'b0;
      end
      if (!pending && cs) begin  // new request seen
        pending   = 1'b1;
        start_cyc = cyc;
        req_adr   = adr;
        req_we    = we;
        req_sel   = sel;
        req_dat   = dat_w;
        req_boot  = boot_sel;
      end
      if (!ack && err !== 1'b0) compare_value("err", '0, QDW'(err));
      if (ack && !pending) begin
        report_failure("ack arrived with no request on the bus");
      end else if (ack) begin
        pending = 1'b0;
        idx     = req_adr.ram_view.word[RAM_AW-1:0];
        if (req_adr.flash_view.region == region_flash && !req_we) exp_lat = 4 * DLY;
        else exp_lat = 1;
        if (cyc - start_cyc != exp_lat) begin
          report_failure($sformatf("ack came %0d cycles after cs, expected %0d",
                                   cyc - start_cyc, exp_lat));
        end
        // only flash writes are refused
        compare_value("err", QDW'(req_adr.flash_view.region == region_flash && req_we),
                      QDW'(err));
        if (req_adr.flash_view.region == region_ram && req_we) begin
          for (int i = 0; i < QSW; i++) begin
            if (req_sel[i]) begin
              shadow[idx][8*i +: 8] = req_dat[8*i +: 8];
              known[idx][i] = 1'b1;
            end
          end
        end else if (!req_we) begin
          rd_check = 1'b1;
          if (req_adr.flash_view.region == region_flash) begin
            rd_exp  = expect_flash_word(req_boot, req_adr.flash_view.word);
            rd_mask = '1;
          end else begin
            rd_exp  = shadow[idx];
            rd_mask = lanes_to_bits(known[idx]);  // unwritten lanes are unknown
          end
        end
      end
      cyc++;
    end
  end

endmodule

// ==== testbench/flash_subsys_asserts.sv ====
////////////////////////////////////////////////////////////
// concurrent checks bound into the flash controller
// ack/err pulse shape and flash pins kept in read mode
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module flash_subsys_asserts (
  input logic                     clk,
  input logic                     rst,
  input logic                     boot_sel,
  input logic                     busy,      // a byte read in flight
  input logic                     we,        // request direction on the bus
  input logic                     ack,
  input logic                     err,
  input logic [qmem_pkg::FAW-1:0] fl_adr,
  input logic                     fl_ce_n,
  input logic                     fl_we_n,
  input logic                     fl_oe_n,
  input logic                     fl_rst_n
);

  int fails = 0;  // failed assertion count

  // err marks a refused write, reads ack clean
  a_err_we: assert property (@(posedge clk) disable iff (rst) ack |-> (err == we))
    else begin
      $error("flash err does not match the request direction");
      fails++;
    end

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else begin
      $error("flash ack longer than one cycle");
      fails++;
    end

  // device leaves reset and is selected one cycle after rst drops
  a_wake: assert property (@(posedge clk) $fell(rst) |=> (fl_rst_n && !fl_ce_n && !fl_oe_n))
    else begin
      $error("flash pins not in read mode one cycle after reset");
      fails++;
    end

  a_stay: assert property (@(posedge clk) disable iff (rst)
                           (fl_rst_n && !fl_ce_n) |=> (fl_rst_n && !fl_ce_n && !fl_oe_n))
    else begin
      $error("flash pins left read mode");
      fails++;
    end

  a_no_we: assert property (@(posedge clk) fl_we_n)
    else begin
      $error("flash write enable asserted");
      fails++;
    end

  // top address bit follows the boot image select
  a_boot: assert property (@(posedge clk) disable iff (rst) busy |-> fl_adr[$high(fl_adr)] == boot_sel)
    else begin
      $error("flash top address bit differs from boot_sel");
      fails++;
    end

endmodule

bind ctrl_flash flash_subsys_asserts asrt0 (
  .clk      (clk),
  .rst      (rst),
  .boot_sel (boot_sel),
  .busy     (state[2]),  // read states only
  .we       (bus.we),
  .ack      (ack_q),
  .err      (err_q),
  .fl_adr   (fl_adr),
  .fl_ce_n  (fl_ce_n),
  .fl_we_n  (fl_we_n),
  .fl_oe_n  (fl_oe_n),
  .fl_rst_n (fl_rst_n)
);

// ==== testbench/tb_flash_subsys.sv ====
////////////////////////////////////////////////////////////
// testbench for the boot memory subsystem, LFSR driven requests
// includes the NOR flash model, timeout and closing report
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_flash_subsys;
  import qmem_pkg::*;

  localparam int DLY    = 3;
  localparam int BE     = 1;
  localparam int RAM_AW = 11;
  localparam int N_REQ  = 300;
  localparam int LIMIT  = N_REQ * (4 * DLY + 4) + 200;  // plus reset and idle margin

  logic           clk;
  logic           rst;
  logic           boot_sel;
  logic [QAW-1:0] adr;
  logic           cs;
  logic           we;
  logic [QSW-1:0] sel;
  logic [QDW-1:0] dat_w;
  logic [QDW-1:0] dat_r;
  logic           ack;
  logic           err;
  logic [FAW-1:0] fl_adr;
  logic           fl_ce_n;
  logic           fl_we_n;
  logic           fl_oe_n;
  logic           fl_rst_n;
  logic [FDW-1:0] fl_dat_r;
  logic [15:0]    lfsr = 16'd48;  // seed
  int             cycles = 0;

  flash_subsys_top #(.DLY(DLY), .BE(BE), .RAM_AW(RAM_AW)) dut0 (
    .clk (clk), .rst (rst), .boot_sel (boot_sel),
    .adr (adr), .cs (cs), .we (we), .sel (sel), .dat_w (dat_w),
    .dat_r (dat_r), .ack (ack), .err (err),
    .fl_adr (fl_adr), .fl_ce_n (fl_ce_n), .fl_we_n (fl_we_n),
    .fl_oe_n (fl_oe_n), .fl_rst_n (fl_rst_n), .fl_dat_r (fl_dat_r)
  );

  flash_subsys_checker #(.DLY(DLY), .BE(BE), .RAM_AW(RAM_AW)) chk0 (
    .clk (clk), .rst (rst), .boot_sel (boot_sel),
    .adr (adr), .cs (cs), .we (we), .sel (sel), .dat_w (dat_w),
    .dat_r (dat_r), .ack (ack), .err (err)
  );

  // NOR flash in read mode, byte follows the address change
  assign #1 fl_dat_r = (!fl_ce_n && !fl_oe_n) ? (fl_adr[7:0] ^ fl_adr[15:8]) : 8'hxx;

  // 16-bit Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;
    return n;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // bus hang guard
  initial begin
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a request never got its ack", LIMIT);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // request stream
  ////////////////////////////////////////////////////////////

  initial begin
    qmem_adr_u   a;
    logic [31:0] r;
    logic        nx_we;
    logic [3:0]  nx_sel;
    logic [31:0] nx_dat;
    int          total;
    rst      = 1'b1;
    boot_sel = 1'b0;
    adr      = '0;
    cs       = 1'b0;
    we       = 1'b0;
    sel      = '0;
    dat_w    = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < N_REQ; n++) begin
      draw_bits(2, r);
      if (r[1:0] == 2'b00) begin  // one idle cycle now and then
        @(posedge clk);
        cs <= 1'b0;
      end
      a = '0;
      draw_bits(1, r);
      a.flash_view.region = r[0];
      if (a.flash_view.region == region_flash) begin
        draw_bits(FL_WORD_W, r);
        a.flash_view.word = r[FL_WORD_W-1:0];
      end else begin
        draw_bits(5, r);  // 32 words, so reads hit earlier writes
        a.ram_view.word = RAM_WORD_W'(r[4:0]);
      end
      draw_bits(2, r);
      a.flash_view.lane = r[1:0];  // ignored by both slaves
      draw_bits(1, r);
      nx_we = r[0];
      draw_bits(4, r);
      nx_sel = r[3:0];
      draw_bits(32, nx_dat);
      @(posedge clk);
      if (n > 0 && n % 50 == 0) boot_sel <= ~boot_sel;  // other boot image
      adr   <= a;
      cs    <= 1'b1;
      we    <= nx_we;
      sel   <= nx_sel;
      dat_w <= nx_dat;
      do begin
        @(negedge clk);
      end while (ack !== 1'b1);
    end
    @(posedge clk);
    cs <= 1'b0;
    repeat (2) @(negedge clk);  // last data cycle
    total = chk0.errors + dut0.flash0.asrt0.fails;
    $display("checks %0d, value errors %0d, assertion failures %0d",
             chk0.checks, chk0.errors, dut0.flash0.asrt0.fails);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
common/qmem_pkg.sv
common/qmem_if.sv
rtl/qmem_decoder.sv
ctrl_flash/ctrl_flash.sv
rtl/scratch_ram.sv
rtl/flash_subsys_top.sv
testbench/flash_subsys_checker.sv
testbench/flash_subsys_asserts.sv
testbench/tb_flash_subsys.sv

// ==== Bender.yml ====
package:
  name: flash_subsys

sources:
  # design, compile order
  - files:
      - common/qmem_pkg.sv
      - common/qmem_if.sv
      - rtl/qmem_decoder.sv
      - ctrl_flash/ctrl_flash.sv
      - rtl/scratch_ram.sv
      - rtl/flash_subsys_top.sv

  # testbench, top module tb_flash_subsys
  - target: test
    files:
      - testbench/flash_subsys_checker.sv
      - testbench/flash_subsys_asserts.sv
      - testbench/tb_flash_subsys.sv
